//--- flist.f
+incdir+design
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_rx_fifo.sv
design/uart_regs.sv
design/uart_top.sv
testbench/uart_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module uart_tb \
    -o uart_tb_sim

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/uart_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- testbench/uart_tb.sv
`include "uart_params.svh"

module uart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int unsigned CLOCK_FREQ = 1_000_000;
    localparam int unsigned BAUD_RATE  = 62_500;
    localparam int unsigned RX_DEPTH   = 4;

    // Symbol period as the line sees it
    // Eleven cycles with these parameters
    localparam int SYMBOL_CYCLES = int'(CLOCK_FREQ / BAUD_RATE) - `UART_FPGA_OFFSET;

    // Status word bits
    localparam logic [31:0] STAT_RX_VALID = 32'h1;
    localparam logic [31:0] STAT_TX_READY = 32'h2;
    localparam logic [31:0] STAT_OVERRUN  = 32'h4;

    localparam int LINE_TIMEOUT = 40 * SYMBOL_CYCLES;
    localparam int POLL_LIMIT   = 200;

    logic        clk = 1'b0;
    logic        rst;
    mmio_req_t   req;
    mmio_rsp_t   rsp;
    logic        line_in;
    logic        loopback;
    logic        serial_in;
    logic        serial_out;
    logic [31:0] lcg_state = 32'd31;

    // 8 ns period
    always #4 clk = ~clk;

    // Loopback routes the transmitter pin back into the receiver
    assign serial_in = loopback ? serial_out : line_in;

    uart_top #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .RX_DEPTH   (RX_DEPTH)
    ) uart_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .serial_in  (serial_in),
        .serial_out (serial_out)
    );

    // Upper bits of the LCG state are the better mixed ones
    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic write_reg(input uart_reg_e addr, input logic [31:0] data);
        @(posedge clk);
        req <= '{en: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        req <= '{en: 1'b0, we: 1'b0, addr: REG_STATUS, wdata: 32'h0};
    endtask

    // Response is due exactly one cycle after the request
    // It lasts a single cycle
    task automatic read_reg(input uart_reg_e addr, output logic [31:0] data);
        @(posedge clk);
        req <= '{en: 1'b1, we: 1'b0, addr: addr, wdata: 32'h0};
        @(posedge clk);
        req <= '{en: 1'b0, we: 1'b0, addr: REG_STATUS, wdata: 32'h0};
        @(negedge clk);
        assert (rsp.rvalid === 1'b1) else begin
            $display("Read response did not arrive one cycle after the request");
            stop_run();
        end
        data = rsp.rdata;
        @(negedge clk);
        assert (rsp.rvalid === 1'b0) else begin
            $display("Read response stayed valid for more than one cycle");
            stop_run();
        end
    endtask

    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] status;
        int          polls;
        polls = 0;
        read_reg(REG_STATUS, status);
        while ((status & mask) !== value) begin
            polls++;
            assert (polls < POLL_LIMIT) else begin
                $display("Timed out waiting for %s in the status register", what);
                stop_run();
            end
            read_reg(REG_STATUS, status);
        end
    endtask

    // Start, 8 data bits LSB first, stop, then one idle symbol
    task automatic send_char(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            line_in <= frame[i];
            repeat (SYMBOL_CYCLES) @(posedge clk);
        end
        // Idle gap so each character starts on a fresh alignment
        repeat (SYMBOL_CYCLES) @(posedge clk);
    endtask

    // Line model for the transmitter sampling at mid-symbol
    task automatic capture_char(output logic [7:0] value);
        int waited;
        waited = 0;
        value = 8'h0;
        while (serial_out !== 1'b0) begin
            @(negedge clk);
            waited++;
            assert (waited < LINE_TIMEOUT) else begin
                $display("No start bit appeared on serial_out");
                stop_run();
            end
        end
        repeat (SYMBOL_CYCLES / 2) @(negedge clk);
        expect_value("serial_out start bit", {31'h0, serial_out}, 32'h0);
        for (int i = 0; i < 8; i++) begin
            repeat (SYMBOL_CYCLES) @(negedge clk);
            value[i] = serial_out;
        end
        repeat (SYMBOL_CYCLES) @(negedge clk);
        expect_value("serial_out stop bit", {31'h0, serial_out}, 32'h1);
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] data;
        logic [7:0]  sent [6];
        logic [7:0]  tx_value;
        logic [7:0]  got;

        rst      = 1'b1;
        req      = '{en: 1'b0, we: 1'b0, addr: REG_STATUS, wdata: 32'h0};
        line_in  = 1'b1;
        loopback = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Idle state after reset
        @(negedge clk);
        expect_value("serial_out after reset", {31'h0, serial_out}, 32'h1);
        expect_value("rsp.rvalid after reset", {31'h0, rsp.rvalid}, 32'h0);
        read_reg(REG_STATUS, status);
        expect_value("status after reset", status, STAT_TX_READY);

        // Transmit one byte while the line model listens
        tx_value = next_random();
        fork
            capture_char(got);
            begin
                write_reg(REG_TX_DATA, {24'h0, tx_value});
                read_reg(REG_STATUS, status);
                expect_value("status tx_ready during frame", status & STAT_TX_READY, 32'h0);
            end
        join
        expect_value("serial_out byte", {24'h0, got}, {24'h0, tx_value});
        wait_status(STAT_TX_READY, STAT_TX_READY, "tx_ready after the frame");

        // Receive one byte
        sent[0] = next_random();
        send_char(sent[0]);
        wait_status(STAT_RX_VALID, STAT_RX_VALID, "rx_valid");
        read_reg(REG_RX_DATA, data);
        expect_value("rx data", data, {24'h0, sent[0]});
        read_reg(REG_STATUS, status);
        expect_value("status after rx read", status, STAT_TX_READY);

        // Empty queue reads as zero
        read_reg(REG_RX_DATA, data);
        expect_value("rx data on empty queue", data, 32'h0);

        // Four characters come back in arrival order
        for (int i = 0; i < 4; i++) begin
            sent[i] = next_random();
            send_char(sent[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_reg(REG_RX_DATA, data);
            expect_value("rx data in order", data, {24'h0, sent[i]});
        end

        // Four bytes fill the queue
        // The fifth waits in the receiver and the sixth overwrites it
        for (int i = 0; i < 6; i++) begin
            sent[i] = next_random();
            send_char(sent[i]);
        end
        read_reg(REG_STATUS, status);
        expect_value("status after overrun", status,
                     STAT_RX_VALID | STAT_TX_READY | STAT_OVERRUN);
        for (int i = 0; i < 4; i++) begin
            read_reg(REG_RX_DATA, data);
            expect_value("rx data before overrun", data, {24'h0, sent[i]});
        end
        read_reg(REG_RX_DATA, data);
        expect_value("rx data after overrun", data, {24'h0, sent[5]});
        read_reg(REG_STATUS, status);
        expect_value("status with sticky overrun", status, STAT_TX_READY | STAT_OVERRUN);
        write_reg(REG_STATUS, STAT_OVERRUN);
        read_reg(REG_STATUS, status);
        expect_value("status after overrun clear", status, STAT_TX_READY);

        // Loopback of transmitter into receiver
        @(posedge clk);
        loopback <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            tx_value = next_random();
            wait_status(STAT_TX_READY, STAT_TX_READY, "tx_ready before loopback write");
            write_reg(REG_TX_DATA, {24'h0, tx_value});
            wait_status(STAT_RX_VALID, STAT_RX_VALID, "rx_valid in loopback");
            read_reg(REG_RX_DATA, data);
            expect_value("loopback rx data", data, {24'h0, tx_value});
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- design/uart_top.sv
`include "uart_params.svh"

module uart_top #(
    parameter int unsigned CLOCK_FREQ = `UART_CLOCK_FREQ,
    parameter int unsigned BAUD_RATE  = `UART_BAUD_RATE,
    parameter int unsigned RX_DEPTH   = `UART_RX_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::mmio_req_t req,
    output uart_pkg::mmio_rsp_t rsp,
    input  logic                serial_in,
    output logic                serial_out
);

    import uart_pkg::*;

    // Receiver into queue
    uart_byte_t rx_to_fifo;
    logic       rx_to_fifo_ready;

    // Queue into register block
    uart_byte_t fifo_to_regs;
    logic       fifo_to_regs_ready;

    // Register block into transmitter
    uart_byte_t regs_to_tx;
    logic       tx_ready;

    logic       rx_overrun;

    uart_rx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_byte   (rx_to_fifo),
        .rx_ready  (rx_to_fifo_ready),
        .overrun   (rx_overrun)
    );

    uart_rx_fifo #(
        .DEPTH (RX_DEPTH)
    ) uart_rx_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .in_byte   (rx_to_fifo),
        .in_ready  (rx_to_fifo_ready),
        .out_byte  (fifo_to_regs),
        .out_ready (fifo_to_regs_ready)
    );

    uart_regs uart_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rsp      (rsp),
        .rx_byte  (fifo_to_regs),
        .rx_ready (fifo_to_regs_ready),
        .overrun  (rx_overrun),
        .tx_byte  (regs_to_tx),
        .tx_ready (tx_ready)
    );

    uart_tx #(
        .CLOCK_FREQ (CLOCK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) uart_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_byte    (regs_to_tx),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

endmodule

//--- design/uart_regs.sv
module uart_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::mmio_req_t  req,
    output uart_pkg::mmio_rsp_t  rsp,
    input  uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_ready,
    input  logic                 overrun,
    output uart_pkg::uart_byte_t tx_byte,
    input  logic                 tx_ready
);

    import uart_pkg::*;

    logic        rd_en;
    logic        wr_en;
    logic        overrun_flag;
    logic        overrun_clear;
    logic [31:0] status_word;
    logic [31:0] rx_word;
    logic [31:0] rdata_next;
    logic [31:0] rdata_q;
    logic        rvalid_q;

    assign rd_en = req.en && !req.we;
    assign wr_en = req.en && req.we;

    // Pop the queue on the same clock as the data read
    assign rx_ready = rd_en && (req.addr == REG_RX_DATA);

    // Single-cycle valid toward the transmitter
    // Dropped if the transmitter is busy
    assign tx_byte = '{valid: wr_en && (req.addr == REG_TX_DATA), data: req.wdata[7:0]};

    // Write one to the overrun bit to clear it
    assign overrun_clear = wr_en && (req.addr == REG_STATUS)
                           && req.wdata[STATUS_OVERRUN_BIT];

    // Sticky, a fresh pulse beats a clear on the same clock
    always_ff @(posedge clk) begin
        if (rst) begin
            overrun_flag <= 1'b0;
        end else if (overrun) begin
            overrun_flag <= 1'b1;
        end else if (overrun_clear) begin
            overrun_flag <= 1'b0;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_RX_VALID_BIT] = rx_byte.valid;
        status_word[STATUS_TX_READY_BIT] = tx_ready;
        status_word[STATUS_OVERRUN_BIT]  = overrun_flag;
    end

    // Empty queue reads as zero
    assign rx_word = rx_byte.valid ? {24'h0, rx_byte.data} : 32'h0;

    // Read mux, the transmit register reads back as zero
    always_comb begin
        case (req.addr)
            REG_STATUS:  rdata_next = status_word;
            REG_RX_DATA: rdata_next = rx_word;
            default:     rdata_next = 32'h0;
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= rdata_next;
        end
    end

    assign rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- design/uart_rx_fifo.sv
`include "uart_params.svh"

module uart_rx_fifo #(
    parameter int unsigned DEPTH = `UART_RX_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t in_byte,
    output logic                 in_ready,
    output uart_pkg::uart_byte_t out_byte,
    input  logic                 out_ready
);

    // Pointers wrap naturally for a power-of-two depth
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign in_ready = !full;
    assign push     = in_byte.valid && !full;
    assign pop      = out_ready && !empty;

    // Storage only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_byte.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of the queue, visible the clock after its push
    assign out_byte = '{valid: !empty, data: mem[rd_ptr]};

endmodule

//--- design/uart_tx.sv
`include "uart_params.svh"

module uart_tx #(
    parameter int unsigned CLOCK_FREQ = `UART_CLOCK_FREQ,
    parameter int unsigned BAUD_RATE  = `UART_BAUD_RATE
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_ready,
    output logic                 serial_out
);

    // Same symbol period as the receiver
    localparam int unsigned SYMBOL_CYCLES = (CLOCK_FREQ / BAUD_RATE) - `UART_FPGA_OFFSET;
    localparam int unsigned CNT_W = $clog2(SYMBOL_CYCLES);
    localparam logic [CNT_W-1:0] EDGE_COUNT = CNT_W'(SYMBOL_CYCLES - 1);

    logic [CNT_W-1:0] clock_count;
    logic [3:0]       bit_count;
    logic [9:0]       frame;
    logic             accept;
    logic             symbol_edge;

    // Idle once every symbol of the frame has gone out
    assign tx_ready = (bit_count == 4'd0);

    assign accept      = tx_byte.valid && tx_ready;
    assign symbol_edge = (clock_count == EDGE_COUNT);

    // Symbols left in the current frame
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_count <= 4'd0;
        end else if (accept) begin
            bit_count <= 4'd10;
        end else if (symbol_edge && !tx_ready) begin
            bit_count <= bit_count - 4'd1;
        end
    end

    // Parked at zero while idle
    always_ff @(posedge clk) begin
        if (rst || accept || symbol_edge) begin
            clock_count <= '0;
        end else if (!tx_ready) begin
            clock_count <= clock_count + 1'b1;
        end
    end

    // Stop bit, data, start bit from MSB down
    // Ones shift in behind the frame so the line rests high
    always_ff @(posedge clk) begin
        if (rst) begin
            frame <= '1;
        end else if (accept) begin
            frame <= {1'b1, tx_byte.data, 1'b0};
        end else if (symbol_edge && !tx_ready) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    // Straight from a flop, no glitches on the pin
    assign serial_out = frame[0];

endmodule

//--- design/uart_rx.sv
`include "uart_params.svh"

module uart_rx #(
    parameter int unsigned CLOCK_FREQ = `UART_CLOCK_FREQ,
    parameter int unsigned BAUD_RATE  = `UART_BAUD_RATE
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 serial_in,
    output uart_pkg::uart_byte_t rx_byte,
    input  logic                 rx_ready,
    output logic                 overrun
);

    // Symbol period in clock cycles, trimmed for the board oscillator
    localparam int unsigned SYMBOL_CYCLES = (CLOCK_FREQ / BAUD_RATE) - `UART_FPGA_OFFSET;
    localparam int unsigned CNT_W = $clog2(SYMBOL_CYCLES);
    localparam logic [CNT_W-1:0] EDGE_COUNT = CNT_W'(SYMBOL_CYCLES - 1);
    localparam logic [CNT_W-1:0] SAMPLE_COUNT = CNT_W'(SYMBOL_CYCLES / 2);

    logic [CNT_W-1:0] clock_count;
    logic [3:0]       bit_count;
    logic [7:0]       data_shift;
    logic [7:0]       data_held;
    logic             has_byte;
    logic             running;
    logic             start;
    logic             symbol_edge;
    logic             sample;
    logic             data_symbol;
    logic             frame_done;

    // Frame in progress while symbols remain
    assign running = (bit_count != 4'd0);

    // Low line while idle is taken as a start bit
    assign start = !serial_in && !running;

    assign symbol_edge = (clock_count == EDGE_COUNT);
    assign sample      = (clock_count == SAMPLE_COUNT);

    // Counts 10 for start, 9..2 for data, 1 for stop
    assign data_symbol = (bit_count >= 4'd2) && (bit_count <= 4'd9);

    // End of the stop-bit symbol
    assign frame_done = running && symbol_edge && (bit_count == 4'd1);

    // Ten symbols per character
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_count <= 4'd0;
        end else if (start) begin
            bit_count <= 4'd10;
        end else if (symbol_edge && running) begin
            bit_count <= bit_count - 4'd1;
        end
    end

    // Realigned to the falling start edge
    always_ff @(posedge clk) begin
        if (rst || start || symbol_edge) begin
            clock_count <= '0;
        end else begin
            clock_count <= clock_count + 1'b1;
        end
    end

    // Mid-symbol sampling, LSB arrives first
    // Start and stop bits are not kept
    always_ff @(posedge clk) begin
        if (sample && data_symbol) begin
            data_shift <= {serial_in, data_shift[7:1]};
        end
    end

    // Byte copy held for the consumer
    // A new character replaces it even if not taken
    always_ff @(posedge clk) begin
        if (frame_done) begin
            data_held <= data_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            has_byte <= 1'b0;
        end else if (frame_done) begin
            has_byte <= 1'b1;
        end else if (rx_ready) begin
            has_byte <= 1'b0;
        end
    end

    // Old byte lost when a frame lands on an untaken byte
    assign overrun = frame_done && has_byte && !rx_ready;

    assign rx_byte = '{valid: has_byte, data: data_held};

endmodule

//--- design/uart_pkg.sv
package uart_pkg;

    // One byte on its way downstream
    // Pairs with a separate ready wire from the consumer
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_byte_t;

    // Register map of the MMIO port
    // Address 3 is unmapped and reads as zero
    typedef enum logic [1:0] {
        REG_STATUS  = 2'd0,
        REG_RX_DATA = 2'd1,
        REG_TX_DATA = 2'd2
    } uart_reg_e;

    // Bit positions inside the status word
    localparam int unsigned STATUS_RX_VALID_BIT = 0;
    localparam int unsigned STATUS_TX_READY_BIT = 1;
    localparam int unsigned STATUS_OVERRUN_BIT  = 2;

    // Host request, accepted on every clock with en high
    typedef struct packed {
        logic        en;
        logic        we;
        uart_reg_e   addr;
        logic [31:0] wdata;
    } mmio_req_t;

    // Read response, one cycle after the request
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } mmio_rsp_t;

endpackage

//--- design/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Default system clock in Hz
`define UART_CLOCK_FREQ 125_000_000

// Default line rate in bits per second
`define UART_BAUD_RATE 115_200

// Cycles trimmed from every symbol period
// The board oscillator runs slightly off nominal
// Without this trim the sample points drift over long bursts
`define UART_FPGA_OFFSET 5

// Default receive queue depth
// Must be a power of two so the pointers wrap on their own
`define UART_RX_DEPTH 8

`endif
